//--- aer_trace.txt
// Fire mask (bit x*4+y per pixel), event count, expected addresses as one hex digit each
// with the first event leftmost; the first value below is the number of bursts
d
0000 0 0
0001 1 0
8000 1 f
0040 1 6
0200 1 9
ffff 10 0145236789cdabef
0420 2 5a
6002 3 1de
8888 4 37bf
0f00 4 89ab
8421 4 05af
1248 4 369c
5a5a 8 14369cbe

//--- sources.f
aer_pkg.sv
scan_arbiter.sv
pixel_level_0.sv
pixel_level_1.sv
aer_readout_top.sv
tb_aer_readout.sv

//--- run_sim.sh
#!/bin/sh
# Build the AER readout testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
    --top-module tb_aer_readout -f sources.f -o sim_aer_readout > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_aer_readout > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && { echo "Simulation reported a failure"; exit 1; } \
    || { echo "Simulation finished without failure"; exit 0; }

//--- tb_aer_readout.sv
// ################################################
// Testbench of the AER readout, replays fire masks from the trace
// file and xorshift masks, checks each event against the scan order
// ################################################
`timescale 1ns/1ns
`default_nettype none

module tb_aer_readout;

    localparam int NUM_PIX          = aer_pkg::NUM_PIX;
    localparam int ARR_COLS         = aer_pkg::ARR_COLS;
    localparam int RESET_CYCLES     = 4;
    localparam int IDLE_CYCLES      = 20;           // Watch time of an empty burst
    localparam int CYCLES_PER_BURST = 40;
    localparam int MAX_TRACE        = 20;           // Bursts the trace memory can hold
    localparam int N_RANDOM         = 12;

    logic                 clk;
    logic                 reset;
    logic [NUM_PIX-1:0]   pix_req;                  // Pixel model request levels
    logic [NUM_PIX-1:0]   pix_gnt;
    logic                 event_valid;
    aer_pkg::event_addr_u event_addr;
    logic                 frame_done;

    logic [63:0]          trace_mem [0:3*MAX_TRACE];  // Count, then mask/count/sequence
    int                   exp_q[$];                 // Addresses still to come this burst
    int                   rule_q[$];                // Order from the scan rule
    logic [NUM_PIX-1:0]   last_gnt;                 // Grant seen in the previous cycle
    logic [NUM_PIX-1:0]   served;                   // Pixels with an event this burst
    logic [NUM_PIX-1:0]   mask;
    logic [63:0]          seq;
    logic [31:0]          rnd;
    int                   count;
    int                   n_trace;
    int                   frame_count;
    int                   error_count;
    int                   check_count;
    int                   cycle_count;
    int                   cycle_limit;

    aer_readout_top i_aer_readout_top (
        .clk_i         (clk),
        .reset_i       (reset),
        .req_i         (pix_req),
        .gnt_o         (pix_gnt),
        .event_valid_o (event_valid),
        .event_addr_o  (event_addr),
        .frame_done_o  (frame_done)
    );

    always #10 clk = ~clk;                          // 20 ns period

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
        end
    endtask

    // Groups row-major, then rows and columns ascending inside a group
    task automatic scan_order(input logic [NUM_PIX-1:0] fire);
        int x;
        int y;
        rule_q.delete();
        for (int gx = 0; gx < aer_pkg::GRP_ROWS; gx++)
            for (int gy = 0; gy < aer_pkg::GRP_COLS; gy++)
                for (int px = 0; px < aer_pkg::PIX_ROWS; px++)
                    for (int py = 0; py < aer_pkg::PIX_COLS; py++)
                    begin
                        x = gx * aer_pkg::PIX_ROWS + px;
                        y = gy * aer_pkg::PIX_COLS + py;
                        if (fire[x * ARR_COLS + y])
                            rule_q.push_back(x * ARR_COLS + y);
                    end
    endtask

    // Pixels drop a request once granted, fired pixels raise one
    task automatic drive_cycle(input logic [NUM_PIX-1:0] fire);
        @(posedge clk);
        #2;
        pix_req = (pix_req & ~last_gnt) | fire;
    endtask

    task automatic check_event();
        int idx;
        int x;
        int y;
        if (last_gnt != '0)
            check_value(event_addr, $clog2(last_gnt), "event address vs granted pixel");
        check_value(exp_q.size() != 0, 1, "event with no pixel left to serve");
        if (exp_q.size() != 0)
        begin
            idx = exp_q.pop_front();
            x   = idx / ARR_COLS;
            y   = idx % ARR_COLS;
            check_value(event_addr.coord.x, x, "event x coordinate");
            check_value(event_addr.coord.y, y, "event y coordinate");
            check_value(event_addr.hier.grp_x, x / aer_pkg::PIX_ROWS, "event group row");
            check_value(event_addr.hier.pix_x, x % aer_pkg::PIX_ROWS, "event pixel row");
            check_value(event_addr.hier.grp_y, y / aer_pkg::PIX_COLS, "event group column");
            check_value(event_addr.hier.pix_y, y % aer_pkg::PIX_COLS, "event pixel column");
        end
        check_value(served[event_addr], 0, "duplicate event");
        served[event_addr] = 1'b1;
    endtask

    // Outputs settle long before the falling edge
    always @(negedge clk)
    begin
        if (!reset)
        begin
            check_value($countones(pix_gnt) > 1, 0, "more than one grant high");
            check_value(pix_gnt & ~pix_req, 0, "grant to a pixel without request");
            check_value(event_valid, last_gnt != '0, "event strobe vs previous grant");
            if (event_valid)
                check_event();
            if (frame_done)
                frame_count++;
            last_gnt = pix_gnt;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout, the DUT did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic run_burst(input logic [NUM_PIX-1:0] fire);
        int frames_before;
        frames_before = frame_count;
        served        = '0;
        drive_cycle(fire);
        if (fire == '0)
            repeat (IDLE_CYCLES) drive_cycle('0);   // Nothing may come out
        else
        begin
            while (frame_count == frames_before)
                drive_cycle('0);
        end
        repeat (2) drive_cycle('0);
        check_value(exp_q.size(), 0, "events missing at end of burst");
        check_value(pix_req, 0, "requests left unserved");
        check_value(frame_count - frames_before, fire != '0, "frame_done pulses in burst");
    endtask

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        pix_req     = '0;
        last_gnt    = '0;
        served      = '0;
        frame_count = 0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        cycle_limit = CYCLES_PER_BURST * (MAX_TRACE + N_RANDOM) + RESET_CYCLES;
        $readmemh("aer_trace.txt", trace_mem);
        if ($isunknown(trace_mem[0]) || trace_mem[0] > MAX_TRACE)
        begin
            $display("Trace file aer_trace.txt is missing or has a bad burst count");
            $display("Verification failed");
            $finish;
        end
        else
        begin
            n_trace     = int'(trace_mem[0]);
            cycle_limit = CYCLES_PER_BURST * (n_trace + N_RANDOM) + RESET_CYCLES;
            repeat (RESET_CYCLES) @(posedge clk);
            #2;
            reset = 1'b0;
            for (int b = 0; b < n_trace; b++)
            begin
                mask  = trace_mem[3*b+1][NUM_PIX-1:0];
                count = int'(trace_mem[3*b+2]);
                seq   = trace_mem[3*b+3];
                exp_q.delete();
                for (int i = count - 1; i >= 0; i--)
                    exp_q.push_back(int'((seq >> (4 * i)) & 64'hf));  // Leftmost digit first
                scan_order(mask);
                check_value(exp_q.size(), rule_q.size(), "trace event count vs scan rule");
                for (int i = 0; i < exp_q.size() && i < rule_q.size(); i++)
                    check_value(exp_q[i], rule_q[i], "trace address vs scan rule");
                run_burst(mask);
            end
            rnd = 32'h2662_9570;
            for (int r = 0; r < N_RANDOM; r++)
            begin
                rnd = next_random(rnd);
                mask = rnd[NUM_PIX-1:0];
                scan_order(mask);
                exp_q = rule_q;
                run_burst(mask);
            end
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0)
                $display("Verification passed");
            else
                $display("Verification failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- aer_readout_top.sv
// ################################################
// AER readout top, four pixel groups under one group arbiter,
// each served pixel leaves as a registered address and strobe
// ################################################
`timescale 1ns/1ns
`default_nettype none

module aer_readout_top (
    input  wire                          clk_i,
    input  wire                          reset_i,
    input  wire  [aer_pkg::NUM_PIX-1:0]  req_i,          // Pixel requests, x-major
    output logic [aer_pkg::NUM_PIX-1:0]  gnt_o,          // Pixel grants, x-major
    output logic                         event_valid_o,  // One cycle per served pixel
    output aer_pkg::event_addr_u         event_addr_o,   // Address of that pixel
    output logic                         frame_done_o    // Group scan wrapped
);

    localparam int GR = aer_pkg::GRP_ROWS;
    localparam int GC = aer_pkg::GRP_COLS;
    localparam int PR = aer_pkg::PIX_ROWS;
    localparam int PC = aer_pkg::PIX_COLS;

    logic [GR-1:0][GC-1:0]  grp_req;
    logic [GR-1:0][GC-1:0]  grp_release;
    logic [GR-1:0][GC-1:0]  grp_en;
    logic [GR-1:0][GC-1:0]  grp_active;            // Group has a pixel grant now
    logic [PR-1:0][PC-1:0]  pix_req [GR][GC];
    logic [PR-1:0][PC-1:0]  pix_gnt [GR][GC];
    logic [aer_pkg::PIX_ADD-1:0] pix_x [GR][GC];
    logic [aer_pkg::PIX_ADD-1:0] pix_y [GR][GC];
    logic [aer_pkg::GRP_ADD-1:0] grp_x;
    logic [aer_pkg::GRP_ADD-1:0] grp_y;

    // Flat array coordinates split into group and local indices
    always_comb
    begin
        for (int x = 0; x < aer_pkg::ARR_ROWS; x++)
        begin
            for (int y = 0; y < aer_pkg::ARR_COLS; y++)
            begin
                pix_req[x / PR][y / PC][x % PR][y % PC] = req_i[x * aer_pkg::ARR_COLS + y];
                gnt_o[x * aer_pkg::ARR_COLS + y] = pix_gnt[x / PR][y / PC][x % PR][y % PC];
            end
        end
    end

    for (genvar gx = 0; gx < GR; gx++)
    begin : g_grp_row
        for (genvar gy = 0; gy < GC; gy++)
        begin : g_grp_col
            pixel_level_0 #(
                .Lvl_ROWS (PR),
                .Lvl_COLS (PC),
                .Lvl_ADD  (aer_pkg::PIX_ADD)
            ) i_pixel_level_0 (
                .clk_i         (clk_i),
                .reset_i       (reset_i),
                .enable_i      (grp_en[gx][gy]),
                .req_i         (pix_req[gx][gy]),
                .gnt_o         (pix_gnt[gx][gy]),
                .x_add_o       (pix_x[gx][gy]),
                .y_add_o       (pix_y[gx][gy]),
                .active_o      (grp_active[gx][gy]),
                .req_o         (grp_req[gx][gy]),
                .grp_release_o (grp_release[gx][gy])
            );
        end
    end

    pixel_level_1 #(
        .Lvl_ROWS (GR),
        .Lvl_COLS (GC),
        .Lvl_ADD  (aer_pkg::GRP_ADD)
    ) i_pixel_level_1 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .grp_req_i     (grp_req),
        .grp_release_i (grp_release),
        .grp_en_o      (grp_en),
        .x_add_o       (grp_x),
        .y_add_o       (grp_y),
        .frame_done_o  (frame_done_o)
    );

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            event_valid_o <= 1'b0;
        else
            event_valid_o <= |grp_active;           // At most one group active
    end

    // Group indices stay put while the group is served
    always_ff @(posedge clk_i)
    begin
        event_addr_o.hier.grp_x <= grp_x;
        event_addr_o.hier.pix_x <= pix_x[grp_x][grp_y];
        event_addr_o.hier.grp_y <= grp_y;
        event_addr_o.hier.pix_y <= pix_y[grp_x][grp_y];
    end

endmodule

`default_nettype wire

//--- pixel_level_1.sv
// ################################################
// Group arbiter, enables one level-0 group at a time in
// row-major order and holds it until the group releases
// ################################################
`timescale 1ns/1ns
`default_nettype none

module pixel_level_1 #(
    parameter int Lvl_ROWS = 2,                     // Group rows
    parameter int Lvl_COLS = 2,                     // Group columns
    parameter int Lvl_ADD  = 1                      // Group index width
) (
    input  wire                               clk_i,
    input  wire                               reset_i,
    input  wire  [Lvl_ROWS-1:0][Lvl_COLS-1:0] grp_req_i,     // Group has requests
    input  wire  [Lvl_ROWS-1:0][Lvl_COLS-1:0] grp_release_i, // Group finished its pass
    output logic [Lvl_ROWS-1:0][Lvl_COLS-1:0] grp_en_o,      // Enable of the served group
    output logic [Lvl_ADD-1:0]                x_add_o,       // Served group row
    output logic [Lvl_ADD-1:0]                y_add_o,       // Served group column
    output logic                              frame_done_o   // All groups served
);

    aer_pkg::arb_state_t state;
    aer_pkg::arb_state_t next_state;

    logic [Lvl_ROWS-1:0] row_req;
    logic [Lvl_COLS-1:0] col_req;
    logic [Lvl_ROWS-1:0] x_gnt;
    logic [Lvl_COLS-1:0] y_gnt;
    logic                x_enable;
    logic                y_enable;
    logic                refresh_x;
    logic                refresh_y;
    logic                x_release;
    logic                y_release;

    assign col_req      = grp_req_i[x_add_o];
    assign frame_done_o = (state == aer_pkg::ROW_GRANT) && x_release;

    always_comb
    begin
        for (int i = 0; i < Lvl_ROWS; i++)
        begin
            row_req[i] = |grp_req_i[i];
            for (int j = 0; j < Lvl_COLS; j++)
            begin
                grp_en_o[i][j] = x_gnt[i] & y_gnt[j];   // Held for the whole group pass
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            state <= aer_pkg::IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        x_enable   = 1'b0;
        y_enable   = 1'b0;
        refresh_x  = 1'b0;
        refresh_y  = 1'b0;
        case (state)
            aer_pkg::IDLE:
            begin
                if (|grp_req_i)
                begin
                    x_enable   = 1'b1;
                    next_state = aer_pkg::ROW_GRANT;
                end
            end
            aer_pkg::ROW_GRANT:
            begin
                if (x_release)
                begin
                    refresh_x  = 1'b1;              // Frame over, back to group 0
                    refresh_y  = 1'b1;
                    next_state = aer_pkg::IDLE;
                end
                else
                begin
                    y_enable   = 1'b1;
                    next_state = aer_pkg::COL_GRANT;
                end
            end
            aer_pkg::COL_GRANT:
            begin
                if (y_release)
                begin
                    refresh_y  = 1'b1;
                    x_enable   = 1'b1;
                    next_state = aer_pkg::ROW_GRANT;
                end
                else
                    y_enable = |(grp_release_i & grp_en_o); // Step only on release
            end
            default: next_state = aer_pkg::IDLE;
        endcase
    end

    scan_arbiter #(.N(Lvl_ROWS), .ADD(Lvl_ADD)) i_row_arbiter (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (x_enable),
        .refresh_i     (refresh_x),
        .req_i         (row_req),
        .gnt_o         (x_gnt),
        .add_o         (x_add_o),
        .grp_release_o (x_release)
    );

    scan_arbiter #(.N(Lvl_COLS), .ADD(Lvl_ADD)) i_col_arbiter (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (y_enable),
        .refresh_i     (refresh_y),
        .req_i         (col_req),
        .gnt_o         (y_gnt),
        .add_o         (y_add_o),
        .grp_release_o (y_release)
    );

    a_one_group: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(grp_en_o))
        else $error("more than one group enabled");

endmodule

`default_nettype wire

//--- pixel_level_0.sv
// ################################################
// Pixel arbiter of one group, picks a row then serves its pixels
// one per cycle, releases the group once its row pass ends
// ################################################
`timescale 1ns/1ns
`default_nettype none

module pixel_level_0 #(
    parameter int Lvl_ROWS = 2,                     // Pixel rows in the group
    parameter int Lvl_COLS = 2,                     // Pixel columns in the group
    parameter int Lvl_ADD  = 1                      // Local index width
) (
    input  wire                               clk_i,
    input  wire                               reset_i,
    input  wire                               enable_i,      // Group selected by level 1
    input  wire  [Lvl_ROWS-1:0][Lvl_COLS-1:0] req_i,         // Pixel request levels
    output logic [Lvl_ROWS-1:0][Lvl_COLS-1:0] gnt_o,         // One-cycle pixel grant
    output logic [Lvl_ADD-1:0]                x_add_o,       // Granted row
    output logic [Lvl_ADD-1:0]                y_add_o,       // Granted column
    output logic                              active_o,      // A pixel is granted now
    output logic                              req_o,         // Any pixel requesting
    output logic                              grp_release_o  // Group pass done
);

    aer_pkg::arb_state_t state;
    aer_pkg::arb_state_t next_state;

    logic [Lvl_ROWS-1:0] row_req;                   // Rows with at least one request
    logic [Lvl_COLS-1:0] col_req;                   // Columns of the granted row
    logic [Lvl_ROWS-1:0] x_gnt;
    logic [Lvl_COLS-1:0] y_gnt;
    logic                x_enable;
    logic                y_enable;
    logic                refresh_x;
    logic                refresh_y;
    logic                x_release;                 // Row pass over
    logic                y_release;                 // Column pass of this row over

    assign req_o   = |req_i;
    assign col_req = req_i[x_add_o];

    always_comb
    begin
        for (int i = 0; i < Lvl_ROWS; i++)
        begin
            row_req[i] = |req_i[i];
        end
    end

    // Pixel grant lives only while the column arbiter holds a grant
    always_comb
    begin
        for (int i = 0; i < Lvl_ROWS; i++)
        begin
            for (int j = 0; j < Lvl_COLS; j++)
            begin
                gnt_o[i][j] = x_gnt[i] & y_gnt[j];
            end
        end
    end

    assign active_o      = |gnt_o;
    assign grp_release_o = enable_i && (state == aer_pkg::ROW_GRANT) && x_release;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            state <= aer_pkg::IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        x_enable   = 1'b0;
        y_enable   = 1'b0;
        refresh_x  = 1'b0;
        refresh_y  = 1'b0;
        if (!enable_i)
        begin
            refresh_x  = 1'b1;                      // Losing enable restarts both passes
            refresh_y  = 1'b1;
            next_state = aer_pkg::IDLE;
        end
        else
        begin
            case (state)
                aer_pkg::IDLE:
                begin
                    x_enable   = 1'b1;              // Pick the first row
                    next_state = aer_pkg::ROW_GRANT;
                end
                aer_pkg::ROW_GRANT:
                begin
                    if (!x_release)
                    begin
                        y_enable   = 1'b1;          // Pick the first column of the row
                        next_state = aer_pkg::COL_GRANT;
                    end
                end
                aer_pkg::COL_GRANT:
                begin
                    if (y_release)
                    begin
                        refresh_y  = 1'b1;          // Row done, step the row arbiter
                        x_enable   = 1'b1;
                        next_state = aer_pkg::ROW_GRANT;
                    end
                    else
                        y_enable = 1'b1;            // Next pixel every cycle
                end
                default: next_state = aer_pkg::IDLE;
            endcase
        end
    end

    scan_arbiter #(.N(Lvl_ROWS), .ADD(Lvl_ADD)) i_row_arbiter (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (x_enable),
        .refresh_i     (refresh_x),
        .req_i         (row_req),
        .gnt_o         (x_gnt),
        .add_o         (x_add_o),
        .grp_release_o (x_release)
    );

    scan_arbiter #(.N(Lvl_COLS), .ADD(Lvl_ADD)) i_col_arbiter (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (y_enable),
        .refresh_i     (refresh_y),
        .req_i         (col_req),
        .gnt_o         (y_gnt),
        .add_o         (y_add_o),
        .grp_release_o (y_release)
    );

    // Level 1 must never pull enable while a pixel is being served
    a_no_gnt_unselected: assert property (@(posedge clk_i) disable iff (reset_i)
        !enable_i |-> (gnt_o == '0))
        else $error("pixel grant while group not enabled");

endmodule

`default_nettype wire

//--- scan_arbiter.sv
// ################################################
// One-pass ordered arbiter over N requests, walks upward from
// the last grant and flags release once nothing is left above
// ################################################
`timescale 1ns/1ns
`default_nettype none

module scan_arbiter #(
    parameter int N   = 2,                          // Number of requesters
    parameter int ADD = 1                           // Index width
) (
    input  wire            clk_i,
    input  wire            reset_i,
    input  wire            enable_i,                // Step to the next request
    input  wire            refresh_i,               // Restart the pass from index 0
    input  wire  [N-1:0]   req_i,                   // Request levels
    output logic [N-1:0]   gnt_o,                   // One-hot grant, held between steps
    output logic [ADD-1:0] add_o,                   // Index of the current grant
    output logic           grp_release_o            // Pass finished
);

    logic           pass_active;                    // A grant was issued in this pass
    logic           found;                          // Candidate exists above pointer
    logic [ADD-1:0] next_idx;                       // Lowest candidate index

    // Descending loop so the lowest qualifying index wins
    always_comb
    begin
        found    = 1'b0;
        next_idx = '0;
        for (int i = N - 1; i >= 0; i--)
        begin
            if (req_i[i] && (!pass_active || i > int'(add_o)))
            begin
                found    = 1'b1;
                next_idx = ADD'(i);
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            gnt_o         <= '0;
            add_o         <= '0;
            pass_active   <= 1'b0;
            grp_release_o <= 1'b0;
        end
        else if (refresh_i)
        begin
            gnt_o         <= '0;                    // Pointer kept, only the pass restarts
            pass_active   <= 1'b0;
            grp_release_o <= 1'b0;
        end
        else if (enable_i)
        begin
            if (found)
            begin
                gnt_o         <= N'(1) << next_idx;
                add_o         <= next_idx;
                pass_active   <= 1'b1;
                grp_release_o <= 1'b0;
            end
            else
            begin
                gnt_o         <= '0;                // Drop grant at end of pass
                grp_release_o <= 1'b1;
            end
        end
    end

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o))
        else $error("scan_arbiter grant not one-hot");

endmodule

`default_nettype wire

//--- aer_pkg.sv
// ################################################
// Array geometry, FSM states and the event address word of the
// AER readout arbiter, referenced by scoped names
// ################################################
`default_nettype none

package aer_pkg;

    parameter int GRP_ROWS = 2;                     // Groups along x
    parameter int GRP_COLS = 2;                     // Groups along y
    parameter int PIX_ROWS = 2;                     // Pixels per group along x
    parameter int PIX_COLS = 2;                     // Pixels per group along y
    parameter int GRP_ADD  = 1;                     // Group index width
    parameter int PIX_ADD  = 1;                     // Local pixel index width

    parameter int ARR_ROWS = GRP_ROWS * PIX_ROWS;   // Pixels along x over the array
    parameter int ARR_COLS = GRP_COLS * PIX_COLS;   // Pixels along y over the array
    parameter int NUM_PIX  = ARR_ROWS * ARR_COLS;   // One request bit per pixel

    // Row-then-column sequencing, used by both arbiter levels
    typedef enum logic [1:0] {
        IDLE      = 2'b00,                          // Nothing in progress
        ROW_GRANT = 2'b01,                          // Row picked or row pass ending
        COL_GRANT = 2'b10                           // Walking the columns of one row
    } arb_state_t;

    typedef union packed {
        struct packed {
            logic [GRP_ADD+PIX_ADD-1:0] x;          // Array row
            logic [GRP_ADD+PIX_ADD-1:0] y;          // Array column
        } coord;
        struct packed {
            logic [GRP_ADD-1:0] grp_x;              // Upper bits of x
            logic [PIX_ADD-1:0] pix_x;              // Row inside the group
            logic [GRP_ADD-1:0] grp_y;              // Upper bits of y
            logic [PIX_ADD-1:0] pix_y;              // Column inside the group
        } hier;
    } event_addr_u;

endpackage

`default_nettype wire
